/* ps2_frame_pkg.sv */
/*
 * PS/2 frame format definitions.
 * frame length, sample point and idle timeout in ticks,
 * and the received-frame struct passed to the register block.
 */

`default_nettype none

package ps2_frame_pkg;

	// ======================================================================
	// frame format
	// ======================================================================

	// start, eight data bits lsb first, odd parity, stop.
	localparam int ps2_frame_bits = 11;

	// ticks of low clock before the data line is taken.
	localparam int ps2_sample_low = 4;

	// ticks of unchanged clock level that end a partial frame.
	localparam int ps2_idle_ticks = 16;

	// ======================================================================
	// received frame
	// ======================================================================

	// result of one complete frame.
	typedef struct packed {
		logic [7:0] code;
		// odd parity over code and parity bit.
		logic       parity_ok;
		// start low and stop high.
		logic       stop_ok;
	} ps2_rx_frame_t;

endpackage

`default_nettype wire

/* ps2_csr_pkg.sv */
/*
 * CSR definitions for the PS/2 receiver.
 * bus struct, register offsets, and the status and control
 * register layouts.
 */

`default_nettype none

package ps2_csr_pkg;

	// ======================================================================
	// bus
	// ======================================================================

	// plain levels, no handshake.
	typedef struct packed {
		logic [13:0] addr;
		logic        we;
		logic [31:0] wdata;
	} ps2_csr_bus_t;

	// ======================================================================
	// register map
	// ======================================================================

	// decoded from addr[1:0].
	localparam logic [1:0] ps2_reg_data   = 2'd0;
	localparam logic [1:0] ps2_reg_status = 2'd1;
	localparam logic [1:0] ps2_reg_ctrl   = 2'd2;

	// status word, low 4 bits.
	// first member is the msb, so pending lands on bit 0.
	typedef struct packed {
		logic frame_err;  // bit 3.
		logic parity_err; // bit 2.
		logic overrun;    // bit 1.
		logic pending;    // bit 0.
	} ps2_status_t;

	// control word, bit 0.
	typedef struct packed {
		logic irq_en;
	} ps2_ctrl_t;

endpackage

`default_nettype wire

/* ps2_line_sampler.sv */
/*
 * PS/2 line sampler.
 * tick divider at 16 x 12.8 kHz, two-flop synchronizers for clock
 * and data, and the run counter of the filtered clock level.
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_line_sampler #(
	parameter int clk_freq = 100000000
) (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst,
	input  wire logic       ps2_clk,
	input  wire logic       ps2_data,
	output logic            tick,
	output logic            clk_level,
	output logic            data_s,
	output logic [4:0]      clk_run
);
	import ps2_frame_pkg::*;

	// ======================================================================
	// tick divider
	// ======================================================================

	// system clocks per tick.
	localparam int div_count = clk_freq / (16 * 12800);
	localparam int div_w = $clog2(div_count);

	logic [div_w-1:0] div_cnt;

	// counts down, reloads at zero.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_cnt <= div_w'(div_count - 1);
		end else if (tick) begin
			div_cnt <= div_w'(div_count - 1);
		end else begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	assign tick = (div_cnt == '0);

	// ======================================================================
	// synchronizers
	// ======================================================================

	logic [1:0] clk_sync;
	logic [1:0] data_sync;

	// lines idle high.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	assign data_s = data_sync[1];

	// ======================================================================
	// clock level tracking
	// ======================================================================

	// level seen at tick rate.
	// run restarts on a change, holds at the idle count.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			clk_level <= 1'b1;
			clk_run   <= '0;
		end else if (tick) begin
			if (clk_level != clk_sync[1]) begin
				clk_level <= clk_sync[1];
				clk_run   <= '0;
			end else if (clk_run != 5'(ps2_idle_ticks)) begin
				clk_run <= clk_run + 1'b1;
			end
		end
	end

	// divider must reload to a nonzero count.
	a_tick_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tick |=> !tick);

endmodule

`default_nettype wire

/* ps2_rx_frame.sv */
/*
 * PS/2 frame receiver.
 * shifts in eleven bits on the low-clock sample point,
 * checks parity and framing, drops partial frames on idle.
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_rx_frame (
	input  wire logic                 sys_clk,
	input  wire logic                 sys_rst,
	input  wire logic                 tick,
	input  wire logic                 clk_level,
	input  wire logic [4:0]           clk_run,
	input  wire logic                 data_s,
	output ps2_frame_pkg::ps2_rx_frame_t frame,
	output logic                      frame_valid
);
	import ps2_frame_pkg::*;

	// ======================================================================
	// sample point and idle detection
	// ======================================================================

	logic sample;
	logic idle;
	logic last_bit;

	// clock low for the sample count.
	assign sample = tick && !clk_level && (clk_run == 5'(ps2_sample_low));

	// clock level unchanged too long.
	assign idle = tick && (clk_run == 5'(ps2_idle_ticks));

	// ======================================================================
	// shift register and bit counter
	// ======================================================================

	logic [ps2_frame_bits-1:0] shift_q;
	logic [3:0]                bit_cnt;

	assign last_bit = (bit_cnt == 4'(ps2_frame_bits - 1));

	// lsb first, so new bits enter at the top.
	always_ff @(posedge sys_clk) begin
		if (sample) begin
			shift_q <= {data_s, shift_q[ps2_frame_bits-1:1]};
		end
	end

	// counter wraps to zero after the stop bit.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bit_cnt <= '0;
		end else if (sample) begin
			if (last_bit) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else if (idle) begin
			// partial frame dropped.
			bit_cnt <= '0;
		end
	end

	// strobe in the cycle after the stop bit is taken.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= sample && last_bit;
		end
	end

	// ======================================================================
	// frame checks
	// ======================================================================

	// shift_q holds the whole frame while frame_valid is high.
	// bit 0 start, 8:1 code, 9 parity, 10 stop.
	assign frame.code      = shift_q[8:1];
	// odd count of ones over code and parity.
	assign frame.parity_ok = ^shift_q[9:1];
	assign frame.stop_ok   = shift_q[10] && !shift_q[0];

	// counter wraps before it can reach the frame length.
	a_bit_cnt_range: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bit_cnt < 4'(ps2_frame_bits));

endmodule

`default_nettype wire

/* ps2_csr_regs.sv */
/*
 * PS/2 register block.
 * scan code, status flags and control, with CSR read mux,
 * write-one-to-clear status and the level irq.
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_csr_regs #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  wire logic                          sys_clk,
	input  wire logic                          sys_rst,
	input  wire ps2_csr_pkg::ps2_csr_bus_t     csr,
	input  wire ps2_frame_pkg::ps2_rx_frame_t  frame,
	input  wire logic                          frame_valid,
	output logic [31:0]                        csr_do,
	output logic                               irq
);
	import ps2_csr_pkg::*;

	// ======================================================================
	// decode
	// ======================================================================

	logic selected;
	logic wr;
	logic frame_good;

	assign selected = (csr.addr[13:10] == csr_addr);
	assign wr = selected && csr.we;
	assign frame_good = frame.parity_ok && frame.stop_ok;

	// ======================================================================
	// registers
	// ======================================================================

	logic [7:0]  data_q;
	ps2_status_t status_q;
	ps2_status_t status_n;
	ps2_ctrl_t   ctrl_q;

	// clear first, then frame events.
	// a flag set by a frame wins over a clear in the same cycle.
	always_comb begin
		status_n = status_q;
		if (wr && (csr.addr[1:0] == ps2_reg_status)) begin
			status_n = ps2_status_t'(status_q & ~csr.wdata[3:0]);
		end
		if (frame_valid) begin
			if (frame_good) begin
				// unread code about to be replaced.
				status_n.overrun = status_n.overrun | status_n.pending;
				status_n.pending = 1'b1;
			end else begin
				status_n.parity_err = status_n.parity_err | !frame.parity_ok;
				status_n.frame_err  = status_n.frame_err | !frame.stop_ok;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			data_q   <= '0;
			status_q <= '0;
			ctrl_q   <= '0;
		end else begin
			status_q <= status_n;
			// bad frames leave the code alone.
			if (frame_valid && frame_good) begin
				data_q <= frame.code;
			end
			if (wr && (csr.addr[1:0] == ps2_reg_ctrl)) begin
				ctrl_q.irq_en <= csr.wdata[0];
			end
		end
	end

	// ======================================================================
	// read mux
	// ======================================================================

	// zero when not selected, offset 3 reads zero.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else if (!selected) begin
			csr_do <= '0;
		end else begin
			case (csr.addr[1:0])
				ps2_reg_data:   csr_do <= {24'd0, data_q};
				ps2_reg_status: csr_do <= {28'd0, status_q};
				ps2_reg_ctrl:   csr_do <= {31'd0, ctrl_q};
				default:        csr_do <= '0;
			endcase
		end
	end

	// level irq.
	assign irq = status_q.pending && ctrl_q.irq_en;

	a_irq_pending: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq |-> status_q.pending);

endmodule

`default_nettype wire

/* ps2_ctrl.sv */
/*
 * PS/2 keyboard receiver, top level.
 * line sampler, frame receiver and register block.
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_ctrl #(
	parameter int         clk_freq = 100000000,
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  wire logic                      sys_clk,
	input  wire logic                      sys_rst,
	input  wire ps2_csr_pkg::ps2_csr_bus_t csr,
	output logic [31:0]                    csr_do,
	output logic                           irq,
	input  wire logic                      ps2_clk,
	input  wire logic                      ps2_data
);
	import ps2_frame_pkg::*;

	// sampler to receiver.
	logic          tick;
	logic          clk_level;
	logic [4:0]    clk_run;
	logic          data_s;

	// receiver to registers.
	ps2_rx_frame_t frame;
	logic          frame_valid;

	ps2_line_sampler #(
		.clk_freq (clk_freq)
	) u_sampler (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.tick      (tick),
		.clk_level (clk_level),
		.data_s    (data_s),
		.clk_run   (clk_run)
	);

	ps2_rx_frame u_rx_frame (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.tick        (tick),
		.clk_level   (clk_level),
		.clk_run     (clk_run),
		.data_s      (data_s),
		.frame       (frame),
		.frame_valid (frame_valid)
	);

	ps2_csr_regs #(
		.csr_addr (csr_addr)
	) u_csr_regs (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.csr         (csr),
		.frame       (frame),
		.frame_valid (frame_valid),
		.csr_do      (csr_do),
		.irq         (irq)
	);

endmodule

`default_nettype wire

/* ps2_ctrl_tb.sv */
/*
 * testbench for the PS/2 keyboard receiver.
 * clock and reset, PS/2 frame driver, CSR access tasks,
 * reference model of status and data, and typed compare tasks.
 */

`timescale 1ns/1ps
`default_nettype none

module ps2_ctrl_tb;
	import ps2_csr_pkg::*;

	// ======================================================================
	// setup
	// ======================================================================

	localparam int         sys_freq = 25000000;
	localparam logic [3:0] block = 4'h3;
	// system clocks per sampler tick.
	localparam int tick_cycles = sys_freq / 204800;
	// kept below the 16-tick idle limit so bits are not dropped.
	localparam int half_ticks = 10;
	localparam int gap_ticks = 24;
	localparam int poll_limit = 50;

	// expected register contents.
	typedef struct packed {
		ps2_status_t status;
		logic [7:0]  data;
	} model_t;

	logic         sys_clk;
	logic         sys_rst;
	ps2_csr_bus_t csr;
	logic [31:0]  csr_do;
	logic         irq;
	logic         ps2_clk;
	logic         ps2_data;

	model_t model;
	logic   irq_en_model;

	ps2_ctrl #(
		.clk_freq (sys_freq),
		.csr_addr (block)
	) u_dut (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.csr      (csr),
		.csr_do   (csr_do),
		.irq      (irq),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data)
	);

	always #20 sys_clk = ~sys_clk;

	// ======================================================================
	// reference and compare
	// ======================================================================

	// next register state after one frame.
	function automatic model_t predict(input model_t prev, input logic [7:0] code,
		input logic bad_parity, input logic bad_stop);
		model_t next;
		next = prev;
		if (!bad_parity && !bad_stop) begin
			next.status.overrun = prev.status.overrun | prev.status.pending;
			next.status.pending = 1'b1;
			next.data = code;
		end else begin
			next.status.parity_err = prev.status.parity_err | bad_parity;
			next.status.frame_err  = prev.status.frame_err | bad_stop;
		end
		return next;
	endfunction

	task automatic stop_on_error(input string what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", what);
	endtask

	task automatic check_data(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			stop_on_error("data word mismatch");
		end
	endtask

	task automatic check_status(input ps2_status_t got, input ps2_status_t exp);
		if (got !== exp) begin
			$display("ERROR: %0t ns status got 0x%01h expected 0x%01h", $time, got, exp);
			stop_on_error("status mismatch");
		end
	endtask

	task automatic check_ctrl(input ps2_ctrl_t got, input ps2_ctrl_t exp);
		if (got !== exp) begin
			$display("ERROR: %0t ns ctrl got %b expected %b", $time, got, exp);
			stop_on_error("control mismatch");
		end
	endtask

	task automatic check_irq(input logic exp);
		if (irq !== exp) begin
			$display("ERROR: %0t ns irq got %b expected %b", $time, irq, exp);
			stop_on_error("irq mismatch");
		end
	endtask

	// ======================================================================
	// bus and line drivers
	// ======================================================================

	// ends 1 ns after a rising edge.
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	// csr_do is valid one cycle after the address.
	task automatic csr_read(input logic [3:0] blk, input logic [1:0] off,
		output logic [31:0] val);
		csr.addr  = {blk, 8'd0, off};
		csr.we    = 1'b0;
		csr.wdata = '0;
		wait_cycles(1);
		val = csr_do;
	endtask

	task automatic csr_write(input logic [1:0] off, input logic [31:0] val);
		csr.addr  = {block, 8'd0, off};
		csr.we    = 1'b1;
		csr.wdata = val;
		wait_cycles(1);
		csr.we    = 1'b0;
		csr.wdata = '0;
	endtask

	// start, code lsb first, parity, stop.
	task automatic send_frame(input logic [7:0] code, input logic bad_parity,
		input logic bad_stop);
		logic [10:0] bits;
		logic        parity;
		parity = ~^code ^ bad_parity;
		bits = {~bad_stop, parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			// data moves in the middle of the high phase.
			wait_cycles(half_ticks / 2 * tick_cycles);
			ps2_data = bits[i];
			wait_cycles(half_ticks / 2 * tick_cycles);
			ps2_clk = 1'b0;
			wait_cycles(half_ticks * tick_cycles);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		wait_cycles(gap_ticks * tick_cycles);
	endtask

	// ======================================================================
	// test steps
	// ======================================================================

	task automatic run_frame(input logic [7:0] code, input logic bad_parity,
		input logic bad_stop);
		model_t      exp;
		logic [31:0] val;
		int          reads;
		exp = predict(model, code, bad_parity, bad_stop);
		send_frame(code, bad_parity, bad_stop);
		reads = 0;
		csr_read(block, ps2_reg_status, val);
		// poll until the flags move.
		while (ps2_status_t'(val[3:0]) == model.status && reads < poll_limit) begin
			csr_read(block, ps2_reg_status, val);
			reads++;
		end
		if (ps2_status_t'(val[3:0]) == model.status) begin
			$display("status did not change within %0d reads after code %02h",
				poll_limit, code);
			stop_on_error("frame not received");
		end
		check_status(ps2_status_t'(val[3:0]), exp.status);
		csr_read(block, ps2_reg_data, val);
		check_data("data", val, {24'd0, exp.data});
		model = exp;
		check_irq(model.status.pending && irq_en_model);
	endtask

	// write one to clear.
	task automatic clear_status(input logic [3:0] mask);
		logic [31:0] val;
		csr_write(ps2_reg_status, {28'd0, mask});
		model.status = ps2_status_t'(model.status & ~mask);
		csr_read(block, ps2_reg_status, val);
		check_data("status word", val, {28'd0, model.status});
		check_irq(model.status.pending && irq_en_model);
	endtask

	task automatic set_irq_en(input logic en);
		logic [31:0] val;
		csr_write(ps2_reg_ctrl, {31'd0, en});
		irq_en_model = en;
		csr_read(block, ps2_reg_ctrl, val);
		check_ctrl(ps2_ctrl_t'(val[0]), ps2_ctrl_t'(en));
		check_data("ctrl word", val, {31'd0, en});
	endtask

	initial begin
		logic [31:0] val;
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr = '0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		model = '0;
		irq_en_model = 1'b0;
		void'($urandom(32'ha213_3931));
		wait_cycles(4);
		sys_rst = 1'b0;

		// reset values.
		csr_read(block, ps2_reg_data, val);
		check_data("data", val, 32'd0);
		csr_read(block, ps2_reg_status, val);
		check_data("status word", val, 32'd0);
		csr_read(block, ps2_reg_ctrl, val);
		check_data("ctrl word", val, 32'd0);
		check_irq(1'b0);

		// random good frames, each cleared.
		for (int i = 0; i < 4; i++) begin
			run_frame(8'($urandom()), 1'b0, 1'b0);
			clear_status(4'b0001);
		end

		// bad frames leave data and pending alone.
		// pending is held set across them.
		run_frame(8'($urandom()), 1'b0, 1'b0);
		run_frame(8'($urandom()), 1'b1, 1'b0);
		clear_status(4'b1100);
		run_frame(8'($urandom()), 1'b0, 1'b1);
		clear_status(4'b1100);
		run_frame(8'($urandom()), 1'b1, 1'b1);
		clear_status(4'hf);

		// second unread code sets overrun.
		run_frame(8'($urandom()), 1'b0, 1'b0);
		run_frame(8'($urandom()), 1'b0, 1'b0);
		clear_status(4'hf);

		// irq follows pending only while enabled.
		set_irq_en(1'b1);
		run_frame(8'($urandom()), 1'b0, 1'b0);
		clear_status(4'b0001);
		set_irq_en(1'b0);
		run_frame(8'($urandom()), 1'b0, 1'b0);

		// other block address reads zero.
		csr_read(4'h5, ps2_reg_data, val);
		check_data("data, other block", val, 32'd0);
		csr_read(4'h5, ps2_reg_status, val);
		check_data("status, other block", val, 32'd0);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* ps2_ctrl.f */
ps2_frame_pkg.sv
ps2_csr_pkg.sv
ps2_line_sampler.sv
ps2_rx_frame.sv
ps2_csr_regs.sv
ps2_ctrl.sv
ps2_ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = ps2_ctrl_tb
FILELIST  = ps2_ctrl.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
